/* customInstructionCore.f */
hdl/ciPkg.sv
hdl/clockingPkg.sv
hdl/resetSequencer.sv
hdl/byteSwapUnit.sv
hdl/microDelayUnit.sv
hdl/ciResultMerger.sv
hdl/customInstructionCore.sv
verif/ciChecker_properties.sv
verif/customInstructionCore_tb.sv

/* hdl/byteSwapUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module byteSwapUnit (
  input  logic             ciStart,
  input  ciPkg::ciOpcode_t ciN,
  input  ciPkg::ciWord_t   ciDataA,
  input  ciPkg::ciWord_t   ciDataB,
  input  logic             coreReset,
  output logic             swapDone,
  output ciPkg::ciWord_t   swapResult
);

  import ciPkg::*;

  ciWord_t fullReverse;
  ciWord_t halfSwap;
  logic    halfMode;

  assign halfMode = ciDataB[swapModeBit];

  // byte 3 becomes byte 0 and so on
  assign fullReverse = {ciDataA[7:0], ciDataA[15:8], ciDataA[23:16], ciDataA[31:24]};

  // only the two bytes of each halfword change places
  assign halfSwap = {ciDataA[23:16], ciDataA[31:24], ciDataA[7:0], ciDataA[15:8]};

  // single cycle, done in the start cycle
  assign swapDone = ciStart && (ciN == swapOpcode) && !coreReset;

  always_comb begin
    if (!swapDone) begin
      // zero keeps the OR merge clean
      swapResult = '0;
    end else if (halfMode) begin
      swapResult = halfSwap;
    end else begin
      swapResult = fullReverse;
    end
  end

endmodule

`default_nettype wire

/* hdl/ciPkg.sv */
`default_nettype none

package ciPkg;

  // operand and result word of the custom-instruction port
  typedef logic [31:0] ciWord_t;

  // custom-instruction number as driven on ciN
  typedef logic [7:0] ciOpcode_t;

  // instruction numbers decoded by the units
  localparam ciOpcode_t swapOpcode  = 8'd1;
  localparam ciOpcode_t delayOpcode = 8'd6;

  // operand B bit that selects swapping inside each halfword
  localparam int swapModeBit = 0;

endpackage

`default_nettype wire

/* hdl/ciResultMerger.sv */
`timescale 1ns/1ps
`default_nettype none

module ciResultMerger (
  input  logic           s_systemClock,
  input  logic           coreReset,
  input  logic           swapDone,
  input  ciPkg::ciWord_t swapResult,
  input  logic           delayDone,
  input  ciPkg::ciWord_t delayResult,
  output logic           ciDone,
  output ciPkg::ciWord_t ciResult
);

  import ciPkg::*;

  logic    mergedDone;
  ciWord_t mergedResult;

  // units that are not selected drive zero, so a plain OR is enough
  assign mergedDone   = swapDone | delayDone;
  assign mergedResult = swapResult | delayResult;

  always_ff @(posedge s_systemClock or posedge coreReset) begin
    if (coreReset) begin
      ciDone <= 1'b0;
    end else begin
      ciDone <= mergedDone;
    end
  end

  // result holds until the next done
  always_ff @(posedge s_systemClock or posedge coreReset) begin
    if (coreReset) begin
      ciResult <= '0;
    end else if (mergedDone) begin
      ciResult <= mergedResult;
    end
  end

endmodule

`default_nettype wire

/* hdl/clockingPkg.sv */
`default_nettype none

package clockingPkg;

  // cycles the core stays in reset once the clock source is locked
  localparam int resetCycles = 16;

  // one bit above the count range, used as the terminal flag
  typedef logic [$clog2(resetCycles):0] resetCount_t;

  // system clocks per microsecond, kept small for short simulations
  localparam int cyclesPerMicrosecond = 4;

  typedef logic [$clog2(cyclesPerMicrosecond)-1:0] prescale_t;

  typedef enum logic {
    delayIdle,
    delayCounting
  } delayState_t;

endpackage

`default_nettype wire

/* hdl/customInstructionCore.sv */
`timescale 1ns/1ps
`default_nettype none

module customInstructionCore (
  input  logic             s_systemClock,
  input  logic             s_pllLocked,
  input  logic             ciStart,
  input  ciPkg::ciOpcode_t ciN,
  input  ciPkg::ciWord_t   ciDataA,
  input  ciPkg::ciWord_t   ciDataB,
  output logic             ciDone,
  output ciPkg::ciWord_t   ciResult,
  output logic             peripheralResetN
);

  import ciPkg::*;

  logic    coreReset;
  logic    swapDone;
  logic    delayDone;
  ciWord_t swapResult;
  ciWord_t delayResult;

  resetSequencer sequencer (
    .s_systemClock    (s_systemClock),
    .s_pllLocked      (s_pllLocked),
    .coreReset        (coreReset),
    .peripheralResetN (peripheralResetN)
  );

  // opcode 1
  byteSwapUnit swapUnit (
    .ciStart    (ciStart),
    .ciN        (ciN),
    .ciDataA    (ciDataA),
    .ciDataB    (ciDataB),
    .coreReset  (coreReset),
    .swapDone   (swapDone),
    .swapResult (swapResult)
  );

  // opcode 6, blocking
  microDelayUnit delayUnit (
    .s_systemClock (s_systemClock),
    .coreReset     (coreReset),
    .ciStart       (ciStart),
    .ciN           (ciN),
    .ciDataA       (ciDataA),
    .delayDone     (delayDone),
    .delayResult   (delayResult)
  );

  ciResultMerger merger (
    .s_systemClock (s_systemClock),
    .coreReset     (coreReset),
    .swapDone      (swapDone),
    .swapResult    (swapResult),
    .delayDone     (delayDone),
    .delayResult   (delayResult),
    .ciDone        (ciDone),
    .ciResult      (ciResult)
  );

endmodule

`default_nettype wire

/* hdl/microDelayUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module microDelayUnit (
  input  logic             s_systemClock,
  input  logic             coreReset,
  input  logic             ciStart,
  input  ciPkg::ciOpcode_t ciN,
  input  ciPkg::ciWord_t   ciDataA,
  output logic             delayDone,
  output ciPkg::ciWord_t   delayResult
);

  import ciPkg::*;
  import clockingPkg::*;

  delayState_t delayState;
  prescale_t   prescale;
  ciWord_t     remaining;
  logic        startDelay;
  logic        zeroDelay;
  logic        microTick;
  logic        lastMicro;

  assign startDelay = ciStart && (ciN == delayOpcode) && !coreReset;

  // a zero delay finishes in the start cycle
  assign zeroDelay = startDelay && (ciDataA == '0);

  // last system clock of the current microsecond
  assign microTick = (delayState == delayCounting) &&
                     (prescale == prescale_t'(cyclesPerMicrosecond - 1));

  assign lastMicro = microTick && (remaining == ciWord_t'(1));

  assign delayDone = zeroDelay || lastMicro;

  always_ff @(posedge s_systemClock or posedge coreReset) begin
    if (coreReset) begin
      delayState <= delayIdle;
      prescale   <= '0;
    end else begin
      case (delayState)
        delayIdle: begin
          prescale <= '0;
          if (startDelay && !zeroDelay) begin
            delayState <= delayCounting;
          end
        end
        delayCounting: begin
          if (microTick) begin
            prescale <= '0;
          end else begin
            prescale <= prescale + prescale_t'(1);
          end
          if (lastMicro) begin
            delayState <= delayIdle;
          end
        end
        default: begin
          delayState <= delayIdle;
          prescale   <= '0;
        end
      endcase
    end
  end

  // microseconds still to wait, counted down once per microsecond
  always_ff @(posedge s_systemClock) begin
    if (startDelay) begin
      remaining <= ciDataA;
    end else if (microTick) begin
      remaining <= remaining - ciWord_t'(1);
    end
  end

  // the delay instruction returns nothing
  assign delayResult = '0;

endmodule

`default_nettype wire

/* hdl/resetSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module resetSequencer (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic coreReset,
  output logic peripheralResetN
);

  import clockingPkg::*;

  resetCount_t resetCount;
  logic        countDone;

  // top bit sets after resetCycles edges and stays set
  assign countDone = resetCount[$bits(resetCount_t)-1];

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      resetCount <= '0;
    end else if (!countDone) begin
      resetCount <= resetCount + resetCount_t'(1);
    end
  end

  assign coreReset        = ~countDone;
  // peripherals come out of reset together with the core
  assign peripheralResetN = countDone;

endmodule

`default_nettype wire

/* runSim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

topModule=customInstructionCore_tb
buildDir=obj_dir
logFile=sim.log

rm -rf "$buildDir"
verilator --binary --timing --assert \
  --top-module "$topModule" \
  --Mdir "$buildDir" \
  -f customInstructionCore.f

# a failing run exits non-zero, the log is inspected below
"./$buildDir/V$topModule" > "$logFile" 2>&1 || true
cat "$logFile"

if grep -q "CHECKS FAILED" "$logFile"; then
  echo "simulation reported failures"
  exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "$logFile"; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

/* verif/ciChecker_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module ciCheckerProperties (
  input logic             s_systemClock,
  input logic             s_pllLocked,
  input logic             coreReset,
  input logic             ciStart,
  input ciPkg::ciOpcode_t ciN,
  input logic             ciDone,
  input logic             peripheralResetN
);

  import ciPkg::*;

  logic delayOutstanding;

  // set by a delay start, cleared once its done is seen
  always_ff @(posedge s_systemClock or posedge coreReset) begin
    if (coreReset) begin
      delayOutstanding <= 1'b0;
    end else if (ciStart && (ciN == delayOpcode)) begin
      delayOutstanding <= 1'b1;
    end else if (ciDone) begin
      delayOutstanding <= 1'b0;
    end
  end

  noDoneInReset: assert property (@(posedge s_systemClock) $rose(ciDone) |-> !coreReset)
    else $error("ciDone rose while the core was in reset");

  singleDelayDone: assert property (@(posedge s_systemClock) disable iff (coreReset)
      (delayOutstanding && ciDone) |=> !ciDone)
    else $error("ciDone stayed high for two cycles after a delay instruction");

  // peripherals only go back into reset when lock is lost
  stableLockReset: assert property (@(posedge s_systemClock)
      s_pllLocked |-> !$fell(peripheralResetN))
    else $error("peripheralResetN fell while the clock source was locked");

endmodule

bind customInstructionCore ciCheckerProperties checker_i (
  .s_systemClock    (s_systemClock),
  .s_pllLocked      (s_pllLocked),
  .coreReset        (coreReset),
  .ciStart          (ciStart),
  .ciN              (ciN),
  .ciDone           (ciDone),
  .peripheralResetN (peripheralResetN)
);

`default_nettype wire

/* verif/customInstructionCore_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module customInstructionCore_tb;

  import ciPkg::*;
  import clockingPkg::*;

  localparam int          clockPeriod   = 40;
  localparam int          driveDelay    = 2;
  localparam logic [31:0] randomSeed    = 32'd22282;
  localparam int          swapTrials    = 24;
  localparam int          burstLength   = 12;
  localparam int          delayTrials   = 12;
  localparam int          unknownTrials = 3;
  localparam int          quietCycles   = 40;
  localparam int          maxDelay      = 5;

  logic      s_systemClock;
  logic      s_pllLocked;
  logic      ciStart;
  ciOpcode_t ciN;
  ciWord_t   ciDataA;
  ciWord_t   ciDataB;
  logic      ciDone;
  ciWord_t   ciResult;
  logic      peripheralResetN;

  logic [31:0] rngState;
  int          cycleCount = 0;
  int          errorCount = 0;
  ciWord_t     lastResult;
  // expected results and the cycle of their ciDone, oldest first
  ciWord_t     expResultQ[$];
  int          expCycleQ[$];

  customInstructionCore dut_i (
    .s_systemClock    (s_systemClock),
    .s_pllLocked      (s_pllLocked),
    .ciStart          (ciStart),
    .ciN              (ciN),
    .ciDataA          (ciDataA),
    .ciDataB          (ciDataB),
    .ciDone           (ciDone),
    .ciResult         (ciResult),
    .peripheralResetN (peripheralResetN)
  );

  initial begin
    s_systemClock = 1'b0;
    forever begin
      #(clockPeriod / 2) s_systemClock = ~s_systemClock;
    end
  end

  always @(posedge s_systemClock) begin
    cycleCount <= cycleCount + 1;
  end

  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // expected result and latency in cycles, latency -1 means no ciDone
  function automatic ciWord_t referenceModel(input ciOpcode_t opcode, input ciWord_t dataA,
                                             input ciWord_t dataB, output int latency);
    ciWord_t result;
    result  = '0;
    latency = -1;
    if (opcode == swapOpcode) begin
      latency = 1;
      for (int i = 0; i < 4; i++) begin
        if (dataB[swapModeBit]) begin
          result[8*i +: 8] = dataA[8*(i ^ 1) +: 8];
        end else begin
          result[8*i +: 8] = dataA[8*(3 - i) +: 8];
        end
      end
    end else if (opcode == delayOpcode) begin
      latency = 1 + cyclesPerMicrosecond * int'(dataA);
    end
    return result;
  endfunction

  task automatic stopOnError(input string reason);
    errorCount++;
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic checkWord(input string name, input ciWord_t actual, input ciWord_t expected);
    if (actual !== expected) begin
      stopOnError($sformatf("FAIL t=%0t %s got %08h expected %08h",
                            $time, name, actual, expected));
    end
  endtask

  task automatic checkStrobe(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      stopOnError($sformatf("FAIL t=%0t %s got %b expected %b",
                            $time, name, actual, expected));
    end
  endtask

  task automatic drawRandom(output logic [31:0] value);
    rngState = lcgNext(rngState);
    value    = rngState;
  endtask

  task automatic nextCycle();
    @(posedge s_systemClock);
    #(driveDelay);
  endtask

  // holds ciStart for one cycle and records what should come back
  task automatic issueStart(input ciOpcode_t opcode, input ciWord_t dataA, input ciWord_t dataB);
    int      latency;
    ciWord_t expected;
    expected = referenceModel(opcode, dataA, dataB, latency);
    ciStart  = 1'b1;
    ciN      = opcode;
    ciDataA  = dataA;
    ciDataB  = dataB;
    if (latency > 0) begin
      expResultQ.push_back(expected);
      expCycleQ.push_back(cycleCount + latency);
    end
    nextCycle();
  endtask

  task automatic waitForDrain(input int limit);
    int waited;
    waited = 0;
    while (expCycleQ.size() != 0) begin
      if (waited >= limit) begin
        stopOnError("timeout while waiting for ciDone of an issued instruction");
      end
      nextCycle();
      waited++;
    end
  endtask

  // compare process, sampled mid-cycle
  initial begin
    logic expectDone;
    lastResult = '0;
    forever begin
      @(negedge s_systemClock);
      expectDone = (expCycleQ.size() != 0) && (expCycleQ[0] == cycleCount);
      checkStrobe("ciDone", ciDone, expectDone);
      if (expectDone) begin
        lastResult = expResultQ.pop_front();
        void'(expCycleQ.pop_front());
      end
      checkWord("ciResult", ciResult, lastResult);
    end
  end

  initial begin
    logic [31:0] dataA;
    logic [31:0] dataB;
    ciOpcode_t   opcode;
    int          lockCycle;
    s_pllLocked = 1'b0;
    ciStart     = 1'b0;
    ciN         = '0;
    ciDataA     = '0;
    ciDataB     = '0;
    rngState    = randomSeed;

    repeat (resetCycles) nextCycle();
    s_pllLocked = 1'b1;
    lockCycle   = cycleCount;
    repeat (resetCycles + 4) begin
      checkStrobe("peripheralResetN", peripheralResetN,
                  (cycleCount - lockCycle) >= resetCycles);
      // starts while the core is held in reset must be ignored
      drawRandom(dataA);
      ciStart = (cycleCount - lockCycle) < (resetCycles - 1);
      ciN     = dataA[0] ? swapOpcode : delayOpcode;
      ciDataA = dataA;
      nextCycle();
    end

    // full byte reversal, one at a time
    repeat (swapTrials) begin
      drawRandom(dataA);
      drawRandom(dataB);
      dataB[swapModeBit] = 1'b0;
      issueStart(swapOpcode, dataA, dataB);
      ciStart = 1'b0;
      waitForDrain(4);
    end

    // halfword swaps back to back
    repeat (burstLength) begin
      drawRandom(dataA);
      drawRandom(dataB);
      dataB[swapModeBit] = 1'b1;
      issueStart(swapOpcode, dataA, dataB);
    end
    ciStart = 1'b0;
    waitForDrain(4);

    repeat (delayTrials) begin
      drawRandom(dataA);
      dataA = (dataA >> 16) % 32'd6;
      drawRandom(dataB);
      issueStart(delayOpcode, dataA, dataB);
      ciStart = 1'b0;
      waitForDrain(cyclesPerMicrosecond * maxDelay + 4);
    end

    // leave a nonzero result so that holding it is visible
    drawRandom(dataA);
    issueStart(swapOpcode, dataA, 32'd0);
    ciStart = 1'b0;
    waitForDrain(4);

    repeat (unknownTrials) begin
      drawRandom(dataA);
      drawRandom(dataB);
      opcode = dataA[31:24];
      while (opcode == swapOpcode || opcode == delayOpcode) begin
        opcode = opcode + 8'd1;
      end
      issueStart(opcode, dataA, dataB);
      ciStart = 1'b0;
      repeat (quietCycles) nextCycle();
    end

    waitForDrain(4);
    if (errorCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
